// File: filelist.f
+incdir+source
source/apb_subsys_pkg.sv
source/periph_bus_decoder.sv
source/apb_gpio_lite.sv
source/apb_pwm_timer.sv
source/apb_soc_ctrl.sv
source/apb_subsystem.sv
testbench/tb_clk_gen.sv
testbench/apb_subsystem_checker.sv
testbench/tb_apb_subsystem.sv

// File: run.sh
#!/bin/sh
# Build and run the APB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f \
   --top-module tb_apb_subsystem -o tb_apb_subsystem
./obj_dir/tb_apb_subsystem

// File: source/apb_gpio_lite.sv
// GPIO direction and output registers with a synchronized read-only input register
`default_nettype none

`include "apb_subsys_defines.svh"

module apb_gpio_lite
   import apb_subsys_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  apb_req_t             apb_req_i,
   input  logic [`NUM_GPIO-1:0] gpio_in_i,
   output apb_rsp_t             apb_rsp_o,
   output logic [`NUM_GPIO-1:0] gpio_out_o,
   output logic [`NUM_GPIO-1:0] gpio_dir_o
);

   localparam reg_idx_t REG_DIR = reg_idx_t'(0);
   localparam reg_idx_t REG_OUT = reg_idx_t'(1);
   localparam reg_idx_t REG_IN  = reg_idx_t'(2);

   reg_idx_t             reg_idx;
   logic                 access;
   logic                 wr_en;
   logic                 hit;
   logic [`NUM_GPIO-1:0] dir_q;
   logic [`NUM_GPIO-1:0] out_q;
   logic [`NUM_GPIO-1:0] sync_q1;
   logic [`NUM_GPIO-1:0] sync_q2;

   assign reg_idx = apb_req_i.paddr[`REG_IDX_MSB:`REG_IDX_LSB];
   assign access  = apb_req_i.psel & apb_req_i.penable;
   assign wr_en   = access & apb_req_i.pwrite;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dir_q <= '0;
         out_q <= '0;
      end else if (wr_en) begin
         if (reg_idx == REG_DIR) begin
            dir_q <= apb_req_i.pwdata[`NUM_GPIO-1:0];
         end else if (reg_idx == REG_OUT) begin
            out_q <= apb_req_i.pwdata[`NUM_GPIO-1:0];
         end
      end
   end

   // Two-flop synchronizer for the pads
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= gpio_in_i;
         sync_q2 <= sync_q1;
      end
   end

   always_comb begin
      apb_rsp_o.prdata = '0;
      hit              = 1'b1;
      case (reg_idx)
         REG_DIR: apb_rsp_o.prdata = `APB_DATA_W'(dir_q);
         REG_OUT: apb_rsp_o.prdata = `APB_DATA_W'(out_q);
         REG_IN:  apb_rsp_o.prdata = `APB_DATA_W'(sync_q2);
         default: hit = 1'b0;
      endcase
      apb_rsp_o.pready  = 1'b1;
      // IN is read only
      apb_rsp_o.pslverr = access & (~hit | (apb_req_i.pwrite & (reg_idx == REG_IN)));
   end

   assign gpio_out_o = out_q;
   assign gpio_dir_o = dir_q;

endmodule

`default_nettype wire

// File: source/apb_pwm_timer.sv
// PWM timer with period, threshold and enable registers, shared counter and channel compare
`default_nettype none

`include "apb_subsys_defines.svh"

module apb_pwm_timer
   import apb_subsys_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  apb_req_t            apb_req_i,
   output apb_rsp_t            apb_rsp_o,
   output logic [`NUM_PWM-1:0] pwm_o
);

   localparam int       THR_SEL_W  = $clog2(`NUM_PWM);
   localparam reg_idx_t REG_PERIOD = reg_idx_t'(0);
   localparam reg_idx_t REG_THR0   = reg_idx_t'(1);
   localparam reg_idx_t REG_CTRL   = reg_idx_t'(`NUM_PWM + 1);

   reg_idx_t                                reg_idx;
   reg_idx_t                                thr_off;
   logic [THR_SEL_W-1:0]                    thr_sel;
   logic                                    is_thr;
   logic                                    access;
   logic                                    wr_en;
   logic [`PWM_CNT_W-1:0]                   period_q;
   logic [`NUM_PWM-1:0][`PWM_CNT_W-1:0]     thr_q;
   logic                                    en_q;
   logic [`PWM_CNT_W-1:0]                   cnt_q;

   assign reg_idx = apb_req_i.paddr[`REG_IDX_MSB:`REG_IDX_LSB];
   assign access  = apb_req_i.psel & apb_req_i.penable;
   assign wr_en   = access & apb_req_i.pwrite;

   // Word 0 wraps to a large offset, so one compare covers the threshold range
   assign thr_off = reg_idx - REG_THR0;
   assign thr_sel = thr_off[THR_SEL_W-1:0];
   assign is_thr  = thr_off < reg_idx_t'(`NUM_PWM);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         period_q <= '0;
         thr_q    <= '0;
         en_q     <= 1'b0;
      end else if (wr_en) begin
         if (reg_idx == REG_PERIOD) begin
            period_q <= apb_req_i.pwdata[`PWM_CNT_W-1:0];
         end else if (is_thr) begin
            thr_q[thr_sel] <= apb_req_i.pwdata[`PWM_CNT_W-1:0];
         end else if (reg_idx == REG_CTRL) begin
            en_q <= apb_req_i.pwdata[0];
         end
      end
   end

   // Counts 0 to PERIOD, parked at 0 while disabled
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (!en_q || (cnt_q >= period_q)) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   always_comb begin
      for (int c = 0; c < `NUM_PWM; c++) begin
         pwm_o[c] = en_q & (cnt_q < thr_q[c]);
      end
   end

   always_comb begin
      apb_rsp_o.prdata = '0;
      if (reg_idx == REG_PERIOD) begin
         apb_rsp_o.prdata = `APB_DATA_W'(period_q);
      end else if (is_thr) begin
         apb_rsp_o.prdata = `APB_DATA_W'(thr_q[thr_sel]);
      end else if (reg_idx == REG_CTRL) begin
         apb_rsp_o.prdata = `APB_DATA_W'(en_q);
      end
      apb_rsp_o.pready  = 1'b1;
      apb_rsp_o.pslverr = access & ~((reg_idx == REG_PERIOD) | is_thr | (reg_idx == REG_CTRL));
   end

endmodule

`default_nettype wire

// File: source/apb_soc_ctrl.sv
// SoC control registers for the cluster control word and the watchdog configuration
`default_nettype none

`include "apb_subsys_defines.svh"

module apb_soc_ctrl
   import apb_subsys_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  apb_req_t               apb_req_i,
   input  logic [`APB_DATA_W-1:0] gwt_cfg_i,
   input  logic                   gwt_cfg_ie_i,
   output apb_rsp_t               apb_rsp_o,
   output logic                   cluster_rstn_o,
   output logic                   cluster_fetch_en_o,
   output logic                   cluster_en_sa_boot_o,
   output logic [`APB_DATA_W-1:0] gwt_cfg_o
);

   localparam reg_idx_t REG_CLUSTER_CTRL = reg_idx_t'(0);
   localparam reg_idx_t REG_GWT_CFG      = reg_idx_t'(1);

   reg_idx_t               reg_idx;
   logic                   access;
   logic                   wr_en;
   logic                   hit;
   cluster_ctrl_u          ctrl_q;
   logic [`APB_DATA_W-1:0] gwt_q;

   assign reg_idx = apb_req_i.paddr[`REG_IDX_MSB:`REG_IDX_LSB];
   assign access  = apb_req_i.psel & apb_req_i.penable;
   assign wr_en   = access & apb_req_i.pwrite;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q.raw <= '0;
      end else if (wr_en && (reg_idx == REG_CLUSTER_CTRL)) begin
         ctrl_q.raw <= apb_req_i.pwdata;
      end
   end

   // Hardware load wins over a bus write in the same cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gwt_q <= '0;
      end else if (gwt_cfg_ie_i) begin
         gwt_q <= gwt_cfg_i;
      end else if (wr_en && (reg_idx == REG_GWT_CFG)) begin
         gwt_q <= apb_req_i.pwdata;
      end
   end

   always_comb begin
      apb_rsp_o.prdata = '0;
      hit              = 1'b1;
      case (reg_idx)
         REG_CLUSTER_CTRL: apb_rsp_o.prdata = ctrl_q.raw;
         REG_GWT_CFG:      apb_rsp_o.prdata = gwt_q;
         default:          hit = 1'b0;
      endcase
      apb_rsp_o.pready  = 1'b1;
      apb_rsp_o.pslverr = access & ~hit;
   end

   assign cluster_rstn_o       = ctrl_q.fields.cluster_rstn;
   assign cluster_fetch_en_o   = ctrl_q.fields.fetch_en;
   assign cluster_en_sa_boot_o = ctrl_q.fields.en_sa_boot;
   assign gwt_cfg_o            = gwt_q;

endmodule

`default_nettype wire

// File: source/apb_subsys_defines.svh
// Bus widths, GPIO and PWM sizes, slave select field and slave indices
`ifndef APB_SUBSYS_DEFINES_SVH
`define APB_SUBSYS_DEFINES_SVH

// APB bus
`define APB_ADDR_W 32
`define APB_DATA_W 32

// Peripheral sizes
`define NUM_GPIO   32
`define NUM_PWM    4
`define PWM_CNT_W  16

// Address field that picks a slave
`define SLV_SEL_MSB 15
`define SLV_SEL_LSB 12

`define SLV_GPIO 0
`define SLV_PWM  1
`define SLV_SOC  2

// Word index inside a slave
`define REG_IDX_MSB 11
`define REG_IDX_LSB 2

`endif

// File: source/apb_subsys_pkg.sv
// APB request and response structs, address field types and the cluster control union
`default_nettype none

`include "apb_subsys_defines.svh"

package apb_subsys_pkg;

   typedef struct packed {
      logic                   psel;
      logic                   penable;
      logic                   pwrite;
      logic [`APB_ADDR_W-1:0] paddr;
      logic [`APB_DATA_W-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [`APB_DATA_W-1:0] prdata;
      logic                   pready;
      logic                   pslverr;
   } apb_rsp_t;

   typedef logic [`SLV_SEL_MSB-`SLV_SEL_LSB:0] slv_sel_t;
   typedef logic [`REG_IDX_MSB-`REG_IDX_LSB:0] reg_idx_t;

   // Bit 0 sits last in a packed struct
   typedef struct packed {
      logic [`APB_DATA_W-4:0] reserved;
      logic                   en_sa_boot;
      logic                   fetch_en;
      logic                   cluster_rstn;
   } cluster_ctrl_fields_t;

   // Bus side sees the raw word, outputs use the fields
   typedef union packed {
      logic [`APB_DATA_W-1:0] raw;
      cluster_ctrl_fields_t   fields;
   } cluster_ctrl_u;

endpackage

`default_nettype wire

// File: source/apb_subsystem.sv
// APB subsystem top with the peripheral decoder, GPIO, PWM timer and SoC control
`default_nettype none

`include "apb_subsys_defines.svh"

module apb_subsystem
   import apb_subsys_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  apb_req_t               apb_req_i,
   input  logic [`NUM_GPIO-1:0]   gpio_in_i,
   input  logic [`APB_DATA_W-1:0] gwt_cfg_i,
   input  logic                   gwt_cfg_ie_i,
   output apb_rsp_t               apb_rsp_o,
   output logic [`NUM_GPIO-1:0]   gpio_out_o,
   output logic [`NUM_GPIO-1:0]   gpio_dir_o,
   output logic [`NUM_PWM-1:0]    pwm_o,
   output logic                   cluster_rstn_o,
   output logic                   cluster_fetch_en_o,
   output logic                   cluster_en_sa_boot_o,
   output logic [`APB_DATA_W-1:0] gwt_cfg_o
);

   apb_req_t gpio_req;
   apb_req_t pwm_req;
   apb_req_t soc_req;
   apb_rsp_t gpio_rsp;
   apb_rsp_t pwm_rsp;
   apb_rsp_t soc_rsp;

   periph_bus_decoder i_periph_bus_decoder (
      .apb_req_i  ( apb_req_i ),
      .gpio_rsp_i ( gpio_rsp  ),
      .pwm_rsp_i  ( pwm_rsp   ),
      .soc_rsp_i  ( soc_rsp   ),
      .gpio_req_o ( gpio_req  ),
      .pwm_req_o  ( pwm_req   ),
      .soc_req_o  ( soc_req   ),
      .apb_rsp_o  ( apb_rsp_o )
   );

   apb_gpio_lite i_apb_gpio (
      .clk_i      ( clk_i      ),
      .rst_n_i    ( rst_n_i    ),
      .apb_req_i  ( gpio_req   ),
      .gpio_in_i  ( gpio_in_i  ),
      .apb_rsp_o  ( gpio_rsp   ),
      .gpio_out_o ( gpio_out_o ),
      .gpio_dir_o ( gpio_dir_o )
   );

   apb_pwm_timer i_apb_pwm_timer (
      .clk_i     ( clk_i   ),
      .rst_n_i   ( rst_n_i ),
      .apb_req_i ( pwm_req ),
      .apb_rsp_o ( pwm_rsp ),
      .pwm_o     ( pwm_o   )
   );

   apb_soc_ctrl i_apb_soc_ctrl (
      .clk_i                ( clk_i                ),
      .rst_n_i              ( rst_n_i              ),
      .apb_req_i            ( soc_req              ),
      .gwt_cfg_i            ( gwt_cfg_i            ),
      .gwt_cfg_ie_i         ( gwt_cfg_ie_i         ),
      .apb_rsp_o            ( soc_rsp              ),
      .cluster_rstn_o       ( cluster_rstn_o       ),
      .cluster_fetch_en_o   ( cluster_fetch_en_o   ),
      .cluster_en_sa_boot_o ( cluster_en_sa_boot_o ),
      .gwt_cfg_o            ( gwt_cfg_o            )
   );

endmodule

`default_nettype wire

// File: source/periph_bus_decoder.sv
// Peripheral APB decoder with select routing, response mux and unmapped-slave error
`default_nettype none

`include "apb_subsys_defines.svh"

module periph_bus_decoder
   import apb_subsys_pkg::*;
(
   input  apb_req_t apb_req_i,
   input  apb_rsp_t gpio_rsp_i,
   input  apb_rsp_t pwm_rsp_i,
   input  apb_rsp_t soc_rsp_i,
   output apb_req_t gpio_req_o,
   output apb_req_t pwm_req_o,
   output apb_req_t soc_req_o,
   output apb_rsp_t apb_rsp_o
);

   slv_sel_t slv_sel;
   logic     access;

   assign slv_sel = apb_req_i.paddr[`SLV_SEL_MSB:`SLV_SEL_LSB];
   assign access  = apb_req_i.psel & apb_req_i.penable;

   // Address, data and strobes go to every slave, psel only to the addressed one
   always_comb begin
      gpio_req_o      = apb_req_i;
      pwm_req_o       = apb_req_i;
      soc_req_o       = apb_req_i;
      gpio_req_o.psel = apb_req_i.psel & (slv_sel == slv_sel_t'(`SLV_GPIO));
      pwm_req_o.psel  = apb_req_i.psel & (slv_sel == slv_sel_t'(`SLV_PWM));
      soc_req_o.psel  = apb_req_i.psel & (slv_sel == slv_sel_t'(`SLV_SOC));
   end

   always_comb begin
      case (slv_sel)
         slv_sel_t'(`SLV_GPIO): begin
            apb_rsp_o = gpio_rsp_i;
         end
         slv_sel_t'(`SLV_PWM): begin
            apb_rsp_o = pwm_rsp_i;
         end
         slv_sel_t'(`SLV_SOC): begin
            apb_rsp_o = soc_rsp_i;
         end
         default: begin
            // Nobody lives here, answer at once with an error
            apb_rsp_o.prdata  = '0;
            apb_rsp_o.pready  = 1'b1;
            apb_rsp_o.pslverr = access;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: testbench/apb_subsystem_checker.sv
// APB handshake, reset value and PWM enable assertions, bound to the subsystem top
`default_nettype none

`include "apb_subsys_defines.svh"

module apb_subsystem_checker
   import apb_subsys_pkg::*;
(
   input logic                clk_i,
   input logic                rst_n_i,
   input apb_req_t            apb_req_i,
   input apb_rsp_t            apb_rsp_i,
   input logic [`NUM_PWM-1:0] pwm_i,
   input logic                cluster_rstn_i,
   input logic                cluster_fetch_en_i,
   input logic                cluster_en_sa_boot_i
);

   logic pwm_ctrl_wr;
   logic pwm_en_seen;

   // PWM enable tracked from bus writes to CTRL
   assign pwm_ctrl_wr = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite &&
      (apb_req_i.paddr[`SLV_SEL_MSB:`SLV_SEL_LSB] == slv_sel_t'(`SLV_PWM)) &&
      (apb_req_i.paddr[`REG_IDX_MSB:`REG_IDX_LSB] == reg_idx_t'(`NUM_PWM + 1));

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pwm_en_seen <= 1'b0;
      end else if (pwm_ctrl_wr) begin
         pwm_en_seen <= apb_req_i.pwdata[0];
      end
   end

   // Zero wait states everywhere
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (apb_req_i.psel && apb_req_i.penable) |-> apb_rsp_i.pready)
   else $error("APB access phase without pready");

   assert property (@(posedge clk_i) apb_rsp_i.pslverr |-> apb_rsp_i.pready)
   else $error("pslverr raised without pready");

   assert property (@(posedge clk_i) !rst_n_i |->
      (pwm_i == '0) && !cluster_rstn_i && !cluster_fetch_en_i && !cluster_en_sa_boot_i)
   else $error("cluster or PWM output not held at 0 during reset");

   assert property (@(posedge clk_i) disable iff (!rst_n_i) !pwm_en_seen |-> (pwm_i == '0))
   else $error("PWM output active while the timer is disabled");

endmodule

bind apb_subsystem apb_subsystem_checker u_apb_subsystem_checker (
   .clk_i                ( clk_i                     ),
   .rst_n_i              ( rst_n_i                   ),
   .apb_req_i            ( apb_req_i                 ),
   .apb_rsp_i            ( apb_rsp_o                 ),
   .pwm_i                ( pwm_o                     ),
   .cluster_rstn_i       ( cluster_rstn_o            ),
   .cluster_fetch_en_i   ( cluster_fetch_en_o        ),
   .cluster_en_sa_boot_i ( cluster_en_sa_boot_o      )
);

`default_nettype wire

// File: testbench/apb_subsystem_stim.txt
# op addr data expected err (hex), W write, R read, G pads, C cluster bits [2:0]
# S gwt load with addr = ie and data = value, P channel addr high cycles over data cycles
R 00000000 00000000 00000000 0
R 00000004 00000000 00000000 0
R 00002000 00000000 00000000 0
R 00002004 00000000 00000000 0
C 00000000 00000000 00000000 0
W 00000000 A5A5F00F 00000000 0
W 00000004 0F0F1234 00000000 0
R 00000000 00000000 A5A5F00F 0
R 00000004 00000000 0F0F1234 0
G 00000000 DEADBEEF 00000000 0
R 00000008 00000000 DEADBEEF 0
W 00001000 00000009 00000000 0
W 00001004 00000003 00000000 0
W 00001008 00000000 00000000 0
W 0000100C 0000000A 00000000 0
W 00001010 0000000F 00000000 0
W 00001014 00000001 00000000 0
R 00001000 00000000 00000009 0
R 0000100C 00000000 0000000A 0
P 00000000 0000000A 00000003 0
P 00000001 0000000A 00000000 0
P 00000002 0000000A 0000000A 0
P 00000003 0000000A 0000000A 0
P 00000000 00000014 00000006 0
W 00002000 00000005 00000000 0
C 00000000 00000000 00000005 0
W 00002000 FFFFFFFA 00000000 0
C 00000000 00000000 00000002 0
R 00002000 00000000 FFFFFFFA 0
W 00002004 12345678 00000000 0
R 00002004 00000000 12345678 0
S 00000001 CAFEF00D 00000000 0
W 00002004 11111111 00000000 0
S 00000000 00000000 00000000 0
R 00002004 00000000 CAFEF00D 0
W 00003000 FFFFFFFF 00000000 1
R 0000F004 00000000 00000000 1
W 0000000C FFFFFFFF 00000000 1
W 00000008 FFFFFFFF 00000000 1
W 00001018 FFFFFFFF 00000000 1
W 00002008 FFFFFFFF 00000000 1
R 00000000 00000000 A5A5F00F 0
R 00000004 00000000 0F0F1234 0
R 00000008 00000000 DEADBEEF 0
R 00001000 00000000 00000009 0
R 00002000 00000000 FFFFFFFA 0
R 00002004 00000000 CAFEF00D 0

// File: testbench/tb_apb_subsystem.sv
// Testbench top with clock, DUT, stimulus file reader, APB driver and checks
`default_nettype none

`include "apb_subsys_defines.svh"

module tb_apb_subsystem
   import apb_subsys_pkg::*;
();

   logic                   clk;
   logic                   rst_n;
   apb_req_t               apb_req;
   apb_rsp_t               apb_rsp;
   logic [`NUM_GPIO-1:0]   gpio_in;
   logic [`NUM_GPIO-1:0]   gpio_out;
   logic [`NUM_GPIO-1:0]   gpio_dir;
   logic [`NUM_PWM-1:0]    pwm;
   logic                   cl_rstn;
   logic                   cl_fetch_en;
   logic                   cl_sa_boot;
   logic [`APB_DATA_W-1:0] gwt_cfg;
   logic                   gwt_cfg_ie;
   logic [`APB_DATA_W-1:0] gwt_cfg_out;

   tb_clk_gen u_clk_gen (
      .clk_o ( clk )
   );

   apb_subsystem u_apb_subsystem (
      .clk_i                ( clk         ),
      .rst_n_i              ( rst_n       ),
      .apb_req_i            ( apb_req     ),
      .gpio_in_i            ( gpio_in     ),
      .gwt_cfg_i            ( gwt_cfg     ),
      .gwt_cfg_ie_i         ( gwt_cfg_ie  ),
      .apb_rsp_o            ( apb_rsp     ),
      .gpio_out_o           ( gpio_out    ),
      .gpio_dir_o           ( gpio_dir    ),
      .pwm_o                ( pwm         ),
      .cluster_rstn_o       ( cl_rstn     ),
      .cluster_fetch_en_o   ( cl_fetch_en ),
      .cluster_en_sa_boot_o ( cl_sa_boot  ),
      .gwt_cfg_o            ( gwt_cfg_out )
   );

   task automatic stop_with_failure();
      $display("=== FAIL ===");
      $fatal(1, "stopped at the first error");
   endtask

   // Setup then access, sampled mid-cycle once pready is seen
   task automatic apb_transfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic slverr);
      int cycles;
      cycles = 0;
      @(posedge clk);
      #1;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge clk);
      #1;
      apb_req.penable = 1'b1;
      @(negedge clk);
      while (!apb_rsp.pready) begin
         if (cycles == 16) begin
            $display("no pready within 16 cycles for address %h at time %0t", addr, $time);
            stop_with_failure();
         end
         cycles++;
         @(negedge clk);
      end
      rdata  = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      @(posedge clk);
      #1;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b0;
   endtask

   // A GWT_CFG write loses to a hardware load in the same cycle
   function automatic logic [31:0] value_after_write(input logic [31:0] addr,
                                                    input logic [31:0] wdata);
      if (addr[`SLV_SEL_MSB:`SLV_SEL_LSB] == slv_sel_t'(`SLV_SOC) &&
          addr[`REG_IDX_MSB:`REG_IDX_LSB] == reg_idx_t'(1) && gwt_cfg_ie) begin
         return gwt_cfg;
      end
      return wdata;
   endfunction

   // DIR and OUT of the GPIO block and GWT_CFG of the SoC control also show up on pins
   task automatic check_output_pins(input logic [31:0] addr, input logic [31:0] exp);
      slv_sel_t sel;
      reg_idx_t idx;
      sel = addr[`SLV_SEL_MSB:`SLV_SEL_LSB];
      idx = addr[`REG_IDX_MSB:`REG_IDX_LSB];
      if (sel == slv_sel_t'(`SLV_GPIO) && idx == reg_idx_t'(0)) begin
         assert (gpio_dir == exp[`NUM_GPIO-1:0]) else begin
            $display("mismatch at %0t: gpio_dir_o %h, expected %h", $time, gpio_dir, exp);
            stop_with_failure();
         end
      end else if (sel == slv_sel_t'(`SLV_GPIO) && idx == reg_idx_t'(1)) begin
         assert (gpio_out == exp[`NUM_GPIO-1:0]) else begin
            $display("mismatch at %0t: gpio_out_o %h, expected %h", $time, gpio_out, exp);
            stop_with_failure();
         end
      end else if (sel == slv_sel_t'(`SLV_SOC) && idx == reg_idx_t'(1)) begin
         assert (gwt_cfg_out == exp) else begin
            $display("mismatch at %0t: gwt_cfg_o %h, expected %h", $time, gwt_cfg_out, exp);
            stop_with_failure();
         end
      end
   endtask

   initial begin
      int          fd;
      int          n;
      int          high;
      int          ops;
      string       line;
      logic [7:0]  op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] exp;
      logic        err_exp;
      logic [31:0] rdata;
      logic        slverr;
      ops        = 0;
      apb_req    = '0;
      gpio_in    = '0;
      gwt_cfg    = '0;
      gwt_cfg_ie = 1'b0;
      rst_n      = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      fd = $fopen("testbench/apb_subsystem_stim.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file");
         stop_with_failure();
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
         end
         n = $sscanf(line, "%c %h %h %h %h", op, addr, data, exp, err_exp);
         if (n != 5) begin
            $display("malformed stimulus line: %s", line);
            stop_with_failure();
         end
         ops++;
         case (op)
            "W", "R": begin
               apb_transfer(op == "W", addr, data, rdata, slverr);
               assert (slverr == err_exp) else begin
                  $display("mismatch at %0t: %c %h pslverr %b, expected %b",
                           $time, op, addr, slverr, err_exp);
                  stop_with_failure();
               end
               if (!err_exp) begin
                  if (op == "R") begin
                     assert (rdata == exp) else begin
                        $display("mismatch at %0t: read %h returned %h, expected %h",
                                 $time, addr, rdata, exp);
                        stop_with_failure();
                     end
                     check_output_pins(addr, exp);
                  end else begin
                     check_output_pins(addr, value_after_write(addr, data));
                  end
               end
            end
            "G": begin
               @(posedge clk);
               #1;
               gpio_in = data[`NUM_GPIO-1:0];
               // Two synchronizer stages before IN sees the pads
               repeat (2) @(posedge clk);
            end
            "S": begin
               @(posedge clk);
               #1;
               gwt_cfg_ie = addr[0];
               gwt_cfg    = data;
            end
            "P": begin
               high = 0;
               for (int i = 0; i < int'(data); i++) begin
                  @(negedge clk);
                  if (pwm[addr[1:0]]) begin
                     high++;
                  end
               end
               assert (high == int'(exp)) else begin
                  $display("mismatch at %0t: channel %0d high for %0d of %0d cycles, expected %0d",
                           $time, addr[1:0], high, data, exp);
                  stop_with_failure();
               end
            end
            "C": begin
               @(negedge clk);
               assert ({cl_sa_boot, cl_fetch_en, cl_rstn} == exp[2:0]) else begin
                  $display("mismatch at %0t: cluster bits %b, expected %b", $time,
                           {cl_sa_boot, cl_fetch_en, cl_rstn}, exp[2:0]);
                  stop_with_failure();
               end
            end
            default: begin
               $display("unknown stimulus operation %c", op);
               stop_with_failure();
            end
         endcase
      end
      $fclose(fd);
      $display("ran %0d stimulus operations", ops);
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
// Free-running testbench clock with a period of 20
`default_nettype none

module tb_clk_gen (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #10 clk_o = ~clk_o;
      end
   end

endmodule

`default_nettype wire
